// ==== dv/clockGen.sv ====
module clockGen #(
  parameter int period = 20
) (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever
      #(period / 2) clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    repeat (2)
      @(posedge clk);   // held over two rising edges
    rst <= 1'b0;
  end

endmodule

// ==== dv/routerTb.sv ====
`include "noc_defines.svh"

module routerTb;

  localparam int clkPeriod    = 20;
  localparam int hereX        = 2;
  localparam int hereY        = 2;
  localparam int numRandPkts  = 40;
  localparam int plannedFlits = 5 * 3 + 2 * 3 + 8 + numRandPkts * 6;
  localparam int watchdogTime = (plannedFlits * 40 + 300) * clkPeriod;   // 40 cycles per flit

  logic                             clk;
  logic                             rst;
  nocPkg::flitLink [`NUM_PORTS-1:0] inLinks;
  logic [`NUM_PORTS-1:0]            creditsOut;
  nocPkg::flitLink [`NUM_PORTS-1:0] outLinks;
  logic [`NUM_PORTS-1:0]            creditsIn;

  logic [31:0]           rngState = 32'h6ea801df;
  int                    credits [`NUM_PORTS];     // sender side of each input link
  int                    pulses [`NUM_PORTS];
  int                    sinkDelay [`NUM_PORTS];
  int                    openSrc [`NUM_PORTS];     // -1 between packets
  logic [`NUM_PORTS-1:0] hold;
  logic [`NUM_PORTS-1:0] returnNow;
  int                    tick;
  int                    pending;
  int                    pktId;
  nocPkg::flit           expQ [`NUM_PORTS][`NUM_PORTS][$];   // per output, per source
  nocPkg::portDir        arrivals [`NUM_PORTS][$];
  int                    dueQ [`NUM_PORTS][$];
  int                    rDx [`NUM_PORTS][$];
  int                    rDy [`NUM_PORTS][$];
  int                    rLen [`NUM_PORTS][$];

  clockGen #(.period(clkPeriod)) clkGen (.clk(clk), .rst(rst));

  meshRouter #(
    .myX (hereX),
    .myY (hereY)
  ) meshRouter_inst (
    .clk        (clk),
    .rst        (rst),
    .inLinks    (inLinks),
    .creditsOut (creditsOut),
    .outLinks   (outLinks),
    .creditsIn  (creditsIn)
  );

  function automatic logic [31:0] nextRand();
    rngState ^= rngState << 13;
    rngState ^= rngState >> 17;
    rngState ^= rngState << 5;
    return rngState;
  endfunction

  // x offset settled first, then y
  function automatic nocPkg::portDir expectedOutput(input int dx, input int dy);
    if (dx != hereX)
      return (dx > hereX) ? nocPkg::dirEast : nocPkg::dirWest;
    if (dy != hereY)
      return (dy > hereY) ? nocPkg::dirNorth : nocPkg::dirSouth;
    return nocPkg::dirLocal;
  endfunction

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic checkFlit(input string name, input nocPkg::flit got, input nocPkg::flit exp);
    if (got !== exp)
    begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      abortRun("flit differs from the reference");
    end
  endtask

  task automatic checkDir(input string name, input nocPkg::portDir got,
                          input nocPkg::portDir exp);
    if (got !== exp)
    begin
      $display("[FAIL] t=%0t %s got %s(%0d) expected %s(%0d)", $time, name,
               got.name(), got, exp.name(), exp);
      abortRun("wrong port direction");
    end
  endtask

  task automatic checkCount(input string name, input int got, input int exp);
    if (got != exp)
    begin
      $display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp);
      abortRun("wrong count");
    end
  endtask

  task automatic checkMask(input string name, input logic [`NUM_PORTS-1:0] got,
                           input logic [`NUM_PORTS-1:0] exp);
    if (got !== exp)
    begin
      $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
      abortRun("wrong bit vector");
    end
  endtask

  task automatic sendPacket(input int src, input int dx, input int dy, input int len);
    nocPkg::flit    pkt [$];
    nocPkg::flit    f;
    nocPkg::portDir o;
    int             id;
    id = pktId;
    pktId++;
    o = expectedOutput(dx, dy);
    for (int k = 0; k < len; k++)
    begin
      f = '0;
      f.isHead = (k == 0);
      f.isTail = (k == len - 1);
      if (k == 0)
      begin
        f.data.head.destX    = `COORD_W'(dx);
        f.data.head.destY    = `COORD_W'(dy);
        f.data.head.len      = `LEN_W'(len);
        f.data.head.reserved = {3'(src), 9'(id)};
      end
      else
        f.data.payload = {4'hA, 8'(k), 8'(id * 3), 3'(src), 9'(id)};
      pkt.push_back(f);
      expQ[o][src].push_back(f);
    end
    pending += len;
    for (int k = 0; k < len; k++)
    begin
      @(posedge clk);
      while (credits[src] == 0)
      begin
        inLinks[src].valid <= 1'b0;
        @(posedge clk);
      end
      inLinks[src] <= '{valid: 1'b1, flt: pkt[k]};
      credits[src]--;
    end
    @(posedge clk);
    inLinks[src].valid <= 1'b0;
  endtask

  task automatic checkArrival(input int o, input nocPkg::flit f);
    int src;
    src = int'(f.data.payload[11:9]);   // source tag sits in the same bits of head and body
    if (src >= `NUM_PORTS || expQ[o][src].size() == 0)
      abortRun($sformatf("output %0d delivered an unexpected flit, source tag %0d", o, src));
    else
    begin
      checkFlit($sformatf("outLinks[%0d].flt", o), f, expQ[o][src].pop_front());
      pending--;
      arrivals[o].push_back(nocPkg::portDir'(src));
      if (f.isHead)
      begin
        checkCount($sformatf("open packet on outLinks[%0d] at head", o), openSrc[o], -1);
        if (!f.isTail)
          openSrc[o] = src;
      end
      else
      begin
        checkCount($sformatf("source of body flit on outLinks[%0d]", o), src, openSrc[o]);
        if (f.isTail)
          openSrc[o] = -1;
      end
    end
  endtask

  // sink side and credit bookkeeping
  always @(negedge clk)
  begin
    if (rst === 1'b0)
    begin
      tick++;
      for (int i = 0; i < `NUM_PORTS; i++)
      begin
        if (creditsOut[i])
        begin
          credits[i]++;
          pulses[i]++;
        end
      end
      for (int o = 0; o < `NUM_PORTS; o++)
      begin
        if (outLinks[o].valid)
        begin
          dueQ[o].push_back(tick + sinkDelay[o]);
          checkArrival(o, outLinks[o].flt);
        end
        returnNow[o] = !hold[o] && dueQ[o].size() > 0 && dueQ[o][0] <= tick;
        if (returnNow[o])
          void'(dueQ[o].pop_front());
      end
    end
  end

  always @(posedge clk)
    creditsIn <= returnNow;

  task automatic waitDrain();
    int owed;
    do
    begin
      @(posedge clk);
      owed = 0;
      for (int o = 0; o < `NUM_PORTS; o++)
        owed += dueQ[o].size();
    end
    while (pending != 0 || owed != 0 || returnNow != '0);
  endtask

  task automatic resetQuiet();
    logic [`NUM_PORTS-1:0] valids;
    while (rst !== 1'b0)
      @(negedge clk);
    repeat (4)
    begin
      @(negedge clk);
      for (int o = 0; o < `NUM_PORTS; o++)
        valids[o] = outLinks[o].valid;
      checkMask("outLinks valid", valids, '0);
      checkMask("creditsOut", creditsOut, '0);
    end
  endtask

  task automatic singlePackets();
    int dx [5] = '{2, 3, 1, 2, 2};   // north, east, west, south, here
    int dy [5] = '{3, 2, 2, 1, 2};
    @(posedge clk);
    for (int d = 0; d < 5; d++)
      sendPacket(nocPkg::dirLocal, dx[d], dy[d], 3);
    waitDrain();
    for (int o = 0; o < `NUM_PORTS; o++)
      checkCount($sformatf("flits on outLinks[%0d]", o), arrivals[o].size(), 3);
  endtask

  // east last served local, so west wins over south
  task automatic sharedOutput();
    @(posedge clk);
    arrivals[nocPkg::dirEast].delete();
    fork
      sendPacket(nocPkg::dirWest, 3, 2, 3);
      sendPacket(nocPkg::dirSouth, 3, 2, 3);
    join
    waitDrain();
    checkCount("flits on East", arrivals[nocPkg::dirEast].size(), 6);
    for (int k = 0; k < 6; k++)
      checkDir($sformatf("source of East flit %0d", k), arrivals[nocPkg::dirEast][k],
               (k < 3) ? nocPkg::dirWest : nocPkg::dirSouth);
  endtask

  task automatic creditStall();
    int base;
    bit sent;
    @(posedge clk);
    base = pulses[nocPkg::dirLocal];
    sent = 1'b0;
    arrivals[nocPkg::dirNorth].delete();
    hold[nocPkg::dirNorth] = 1'b1;
    fork
      begin
        sendPacket(nocPkg::dirLocal, 2, 4, 8);
        sent = 1'b1;
      end
    join_none
    repeat (40)
      @(posedge clk);
    checkCount("flits on North while held", arrivals[nocPkg::dirNorth].size(), `BUF_DEPTH);
    hold[nocPkg::dirNorth] = 1'b0;
    wait (sent);
    waitDrain();
    checkCount("flits on North", arrivals[nocPkg::dirNorth].size(), 8);
    checkCount("creditsOut pulses of Local", pulses[nocPkg::dirLocal] - base, 8);
  endtask

  task automatic sendList(input int src);
    for (int k = 0; k < rDx[src].size(); k++)
      sendPacket(src, rDx[src][k], rDy[src][k], rLen[src][k]);
  endtask

  task automatic randomTraffic();
    int src;
    @(posedge clk);
    for (int o = 0; o < `NUM_PORTS; o++)
      sinkDelay[o] = int'(nextRand() % 6);
    for (int n = 0; n < numRandPkts; n++)
    begin
      src = int'(nextRand() % `NUM_PORTS);
      rDx[src].push_back(int'(nextRand() % 5));
      rDy[src].push_back(int'(nextRand() % 5));
      rLen[src].push_back(1 + int'(nextRand() % 6));
    end
    fork
      sendList(0);
      sendList(1);
      sendList(2);
      sendList(3);
      sendList(4);
    join
    waitDrain();
    for (int i = 0; i < `NUM_PORTS; i++)
      checkCount($sformatf("sender credits of input %0d", i), credits[i], `BUF_DEPTH);
  endtask

  initial
  begin
    #(watchdogTime);
    abortRun($sformatf("watchdog expired with %0d flits still missing", pending));
  end

  initial
  begin
    inLinks   = '0;
    creditsIn = '0;
    hold      = '0;
    returnNow = '0;
    tick      = 0;
    pending   = 0;
    pktId     = 0;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      credits[i]   = `BUF_DEPTH;
      pulses[i]    = 0;
      sinkDelay[i] = 0;
      openSrc[i]   = -1;
    end
    resetQuiet();
    singlePackets();
    sharedOutput();
    creditStall();
    randomTraffic();
    $display("test passed");
    $finish;
  end

endmodule

// ==== verilog/inputPort.sv ====
`include "noc_defines.svh"

module inputPort #(
  parameter int myX = 0,
  parameter int myY = 0
) (
  input  logic            clk,
  input  logic            rst,
  input  nocPkg::flitLink inFlit,
  output logic            creditOut,
  input  logic            pop,
  output nocPkg::portReq  req,
  output nocPkg::flit     headFlit
);

  localparam int PtrW = $clog2(`BUF_DEPTH);
  localparam logic [`COORD_W-1:0] hereX = `COORD_W'(myX);
  localparam logic [`COORD_W-1:0] hereY = `COORD_W'(myY);

  nocPkg::flit       mem [`BUF_DEPTH];
  logic [PtrW-1:0]   wrPtr;
  logic [PtrW-1:0]   rdPtr;
  logic [PtrW:0]     count;
  logic              empty;
  logic              full;
  logic              doPop;
  nocPkg::headFields dest;
  nocPkg::portDir    routeDir;
  nocPkg::portDir    heldDir;
  logic [`LEN_W-1:0] heldLen;
  logic              pktOpen;   // head popped, tail not yet

  assign empty     = (count == '0);
  assign full      = (count == (PtrW+1)'(`BUF_DEPTH));
  assign doPop     = pop && !empty;
  assign headFlit  = mem[rdPtr];
  assign dest      = headFlit.data.head;
  assign creditOut = doPop;   // one credit per flit leaving

  always_ff @(posedge clk)
  begin
    if (inFlit.valid)
      mem[wrPtr] <= inFlit.flt;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (inFlit.valid)
        wrPtr <= wrPtr + 1'b1;
      if (doPop)
        rdPtr <= rdPtr + 1'b1;
      count <= count + (PtrW+1)'(inFlit.valid) - (PtrW+1)'(doPop);
    end
  end

  // XY order, x first
  always_comb
  begin
    routeDir = nocPkg::dirLocal;
    if (dest.destX > hereX)
      routeDir = nocPkg::dirEast;
    else if (dest.destX < hereX)
      routeDir = nocPkg::dirWest;
    else if (dest.destY > hereY)
      routeDir = nocPkg::dirNorth;
    else if (dest.destY < hereY)
      routeDir = nocPkg::dirSouth;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      pktOpen <= 1'b0;
    else if (doPop)
      pktOpen <= !headFlit.isTail;
  end

  always_ff @(posedge clk)
  begin
    if (doPop && headFlit.isHead)
    begin
      heldDir <= routeDir;
      heldLen <= dest.len;
    end
  end

  always_comb
  begin
    req.req    = !empty;
    req.target = pktOpen ? heldDir : routeDir;   // body flits follow the head
    req.len    = pktOpen ? heldLen : dest.len;
  end

  // upstream sender runs out of credits before this can happen
  noOverflow: assert property (@(posedge clk) disable iff (rst) inFlit.valid |-> !full)
    else $error("flit arrived at a full input fifo");

endmodule

// ==== verilog/meshRouter.sv ====
`include "noc_defines.svh"

module meshRouter #(
  parameter int myX = 0,
  parameter int myY = 0
) (
  input  logic                             clk,
  input  logic                             rst,
  input  nocPkg::flitLink [`NUM_PORTS-1:0] inLinks,
  output logic [`NUM_PORTS-1:0]            creditsOut,
  output nocPkg::flitLink [`NUM_PORTS-1:0] outLinks,
  input  logic [`NUM_PORTS-1:0]            creditsIn
);

  nocPkg::portReq [`NUM_PORTS-1:0] reqs;
  nocPkg::flit [`NUM_PORTS-1:0]    heads;
  logic [`NUM_PORTS-1:0]           popByOut [`NUM_PORTS];   // per output, bit per input
  logic [`NUM_PORTS-1:0]           inPop;

  always_comb
  begin
    inPop = '0;
    for (int o = 0; o < `NUM_PORTS; o++)
      inPop = inPop | popByOut[o];
  end

  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : gIn
    inputPort #(
      .myX (myX),
      .myY (myY)
    ) inPort (
      .clk       (clk),
      .rst       (rst),
      .inFlit    (inLinks[i]),
      .creditOut (creditsOut[i]),
      .pop       (inPop[i]),
      .req       (reqs[i]),
      .headFlit  (heads[i])
    );
  end

  for (genvar o = 0; o < `NUM_PORTS; o++)
  begin : gOut
    outputPort outPort (
      .clk      (clk),
      .rst      (rst),
      .myDir    (nocPkg::portDir'(o)),
      .reqs     (reqs),
      .heads    (heads),
      .creditIn (creditsIn[o]),
      .outFlit  (outLinks[o]),
      .pops     (popByOut[o])
    );
  end

endmodule

// ==== verilog/nocPkg.sv ====
`include "noc_defines.svh"

package nocPkg;

  typedef enum logic [2:0] {
    dirLocal = 3'd0,
    dirNorth = 3'd1,
    dirEast  = 3'd2,
    dirWest  = 3'd3,
    dirSouth = 3'd4
  } portDir;

  typedef struct packed {
    logic [`COORD_W-1:0]                     destX;
    logic [`COORD_W-1:0]                     destY;
    logic [`LEN_W-1:0]                       len;      // flits incl. head
    logic [`DATA_W-2*`COORD_W-`LEN_W-1:0]   reserved;
  } headFields;

  // header on head flits, raw payload on the rest
  typedef union packed {
    headFields          head;
    logic [`DATA_W-1:0] payload;
  } flitData;

  typedef struct packed {
    logic    isHead;
    logic    isTail;
    flitData data;
  } flit;

  typedef struct packed {
    logic valid;
    flit  flt;
  } flitLink;

  typedef struct packed {
    logic              req;
    portDir            target;
    logic [`LEN_W-1:0] len;     // only meaningful while the head is at the front
  } portReq;

endpackage

// ==== verilog/noc_defines.svh ====
`ifndef NOC_DEFINES_SVH
`define NOC_DEFINES_SVH

// fifo slots per input, also starting credits per output
`define BUF_DEPTH 4

// holds 0..BUF_DEPTH
`define CREDIT_W ($clog2(`BUF_DEPTH) + 1)

`define DATA_W 32
`define COORD_W 4
`define LEN_W 12

// local, north, east, west, south
`define NUM_PORTS 5

`endif

// ==== verilog/outputArbiter.sv ====
`include "noc_defines.svh"

module outputArbiter (
  input  logic                            clk,
  input  logic                            rst,
  input  nocPkg::portReq [`NUM_PORTS-1:0] reqs,
  input  nocPkg::portDir                  myDir,
  input  logic                            advance,
  output logic [`NUM_PORTS-1:0]           grant,
  output logic                            busy
);

  localparam int IdxW = $clog2(`NUM_PORTS);

  logic [`NUM_PORTS-1:0] wants;
  logic [IdxW-1:0]       prio;        // first input looked at when idle
  logic [IdxW-1:0]       curIdx;
  logic [IdxW-1:0]       pickIdx;
  logic                  pickValid;
  logic [`LEN_W-1:0]     remaining;   // flits left in the granted packet

  function automatic logic [IdxW-1:0] nextPort(input logic [IdxW-1:0] idx);
    return (idx == IdxW'(`NUM_PORTS - 1)) ? '0 : idx + 1'b1;
  endfunction

  always_comb
  begin
    for (int i = 0; i < `NUM_PORTS; i++)
      wants[i] = reqs[i].req && (reqs[i].target == myDir);
  end

  // rotating search from prio
  always_comb
  begin
    int idx;
    pickValid = 1'b0;
    pickIdx   = prio;
    for (int k = 0; k < `NUM_PORTS; k++)
    begin
      idx = (int'(prio) + k) % `NUM_PORTS;
      if (!pickValid && wants[idx])
      begin
        pickValid = 1'b1;
        pickIdx   = IdxW'(idx);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy      <= 1'b0;
      grant     <= '0;
      prio      <= '0;   // local first after reset
      curIdx    <= '0;
      remaining <= '0;
    end
    else if (!busy)
    begin
      if (pickValid)
      begin
        busy      <= 1'b1;
        grant     <= `NUM_PORTS'(1) << pickIdx;
        curIdx    <= pickIdx;
        remaining <= reqs[pickIdx].len;
      end
    end
    else if (advance)
    begin
      if (remaining <= `LEN_W'(1))
      begin
        // times up so the next port gets its turn
        busy  <= 1'b0;
        grant <= '0;
        prio  <= nextPort(curIdx);
      end
      else
        remaining <= remaining - 1'b1;
    end
  end

  grantOneHot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant) && (busy == (grant != '0)))
    else $error("arbiter grant not one-hot or out of step with busy");

endmodule

// ==== verilog/outputPort.sv ====
`include "noc_defines.svh"

module outputPort (
  input  logic                            clk,
  input  logic                            rst,
  input  nocPkg::portDir                  myDir,
  input  nocPkg::portReq [`NUM_PORTS-1:0] reqs,
  input  nocPkg::flit [`NUM_PORTS-1:0]    heads,
  input  logic                            creditIn,
  output nocPkg::flitLink                 outFlit,
  output logic [`NUM_PORTS-1:0]           pops
);

  logic [`NUM_PORTS-1:0] grant;
  logic                  busy;
  logic [`NUM_PORTS-1:0] ready;
  logic                  send;
  logic                  hasCredit;
  logic [`CREDIT_W-1:0]  credits;   // free slots downstream
  nocPkg::flit           selFlit;
  logic                  outValid;
  nocPkg::flit           outData;

  outputArbiter arb (
    .clk     (clk),
    .rst     (rst),
    .reqs    (reqs),
    .myDir   (myDir),
    .advance (send),
    .grant   (grant),
    .busy    (busy)
  );

  // crossbar column for this output
  always_comb
  begin
    selFlit = '0;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      ready[i] = reqs[i].req;
      if (grant[i])
        selFlit = heads[i];
    end
  end

  assign hasCredit = (credits != '0);
  assign pops      = grant & ready & {`NUM_PORTS{busy && hasCredit}};
  assign send      = |pops;

  always_ff @(posedge clk)
  begin
    if (rst)
      credits <= `CREDIT_W'(`BUF_DEPTH);
    else
      credits <= credits + `CREDIT_W'(creditIn) - `CREDIT_W'(send);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= send;
  end

  always_ff @(posedge clk)
  begin
    if (send)
      outData <= selFlit;
  end

  assign outFlit = '{valid: outValid, flt: outData};

  // downstream returns no more credits than it has slots
  creditBound: assert property (@(posedge clk) disable iff (rst)
    credits <= `CREDIT_W'(`BUF_DEPTH))
    else $error("output credit count above buffer depth");

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/nocPkg.sv
verilog/inputPort.sv
verilog/outputArbiter.sv
verilog/outputPort.sv
verilog/meshRouter.sv
dv/clockGen.sv
dv/routerTb.sv
